// ==== sim.f ====
hdl/bch_pkg.sv
hdl/bch_syndrome_calc.sv
hdl/bch_syndrome_buffer.sv
hdl/bch_eras_berlekamp_ribm_2t.sv
hdl/bch_eras_decoder.sv
bench/tb_bch_eras_decoder.sv

// ==== run.sh ====
#!/bin/sh
# build and run the BCH erasure decoder testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bch_eras_decoder \
  -f sim.f \
  -o sim_tb
# a $fatal in the bench gives a non-zero exit status
./obj_dir/sim_tb

// ==== bench/tb_bch_eras_decoder.sv ====
module tb_bch_eras_decoder
  import bch_pkg::*;
();

  localparam int n_words        = 300;
  localparam int timeout_cycles = 200;

  logic  iclk;
  logic  ireset;
  logic  iclkena;
  logic  ival;
  logic  isop;
  logic  ieop;
  logic  idat;
  logic  iera;
  ptr_t  iptr;
  logic  oloc_poly_val;
  ptr_t  oloc_poly_ptr;
  data_t oloc_poly [2][0:t];

  // reference field tables, alpha^k and its inverse
  int exp_tab [0:n-1];
  int log_tab [0:n];

  // scoreboard, tag and per-copy differing positions
  ptr_t         ptr_q   [$];
  logic [n-1:0] mask0_q [$];
  logic [n-1:0] mask1_q [$];

  bch_eras_decoder DUT (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .ival          (ival),
    .isop          (isop),
    .ieop          (ieop),
    .idat          (idat),
    .iera          (iera),
    .iptr          (iptr),
    .oloc_poly_val (oloc_poly_val),
    .oloc_poly_ptr (oloc_poly_ptr),
    .oloc_poly     (oloc_poly)
  );

  initial iclk = 1'b0;
  always #2 iclk = ~iclk;

  // --------------------------------------------------------------------------
  // reporting
  // --------------------------------------------------------------------------

  task automatic check_eq(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_with(input string reason);
    $display("%s at t=%0t", reason, $time);
    $display("SOME TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // --------------------------------------------------------------------------
  // GF(2^4) reference
  // --------------------------------------------------------------------------

  task automatic build_tables();
    int v;
    v = 1;
    for (int k = 0; k < n; k++) begin
      exp_tab[k] = v;
      log_tab[v] = k;
      v = v << 1;
      // reduce by x^4+x+1
      if ((v & 16) != 0) begin
        v = v ^ irrpol;
      end
    end
  endtask

  // locator value at alpha^(-pos)
  function automatic int eval_at_inverse(input data_t coef [0:t], input int pos);
    int acc;
    int e;
    acc = 0;
    for (int k = 0; k <= t; k++) begin
      if (coef[k] != '0) begin
        e = (log_tab[int'(coef[k])] - pos * k) % n;
        if (e < 0) begin
          e = e + n;
        end
        acc = acc ^ exp_tab[e];
      end
    end
    return acc;
  endfunction

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  // retries until the beat lands in an enabled cycle
  task automatic drive_beat(input logic val, input logic sop, input logic eop,
                            input logic dat, input logic era, input ptr_t tag);
    logic ena;
    int   tries;
    ena   = 1'b0;
    tries = 0;
    while (!ena) begin
      @(posedge iclk);
      #1;
      ena     = ($urandom % 10) != 0;
      iclkena = ena;
      ival    = val;
      isop    = sop;
      ieop    = eop;
      idat    = dat;
      iera    = era;
      iptr    = tag;
      tries++;
      if (tries > timeout_cycles) begin
        abort_with("clock enable never went high for a beat");
      end
    end
  endtask

  task automatic send_codeword(input ptr_t tag);
    logic [4:0]   msg;
    logic [n-1:0] cw;
    logic [n-1:0] errs;
    logic [n-1:0] eras;
    logic [n-1:0] used;
    int           n_err;
    int           n_era;
    int           pos;
    logic         b;
    msg = 5'($urandom);
    cw  = '0;
    // codeword = msg(x) * g(x), carry-less
    for (int i = 0; i < 5; i++) begin
      if (msg[i]) begin
        cw = cw ^ (15'h537 << i);
      end
    end
    errs  = '0;
    eras  = '0;
    used  = '0;
    n_err = int'($urandom % 3);
    n_era = int'($urandom % 3);
    for (int k = 0; k < n_err + n_era; k++) begin
      pos = int'($urandom % n);
      while (used[pos]) begin
        pos = int'($urandom % n);
      end
      used[pos] = 1'b1;
      if (k < n_err) begin
        errs[pos] = 1'b1;
      end else begin
        eras[pos] = 1'b1;
      end
    end
    // x^14 first, x^0 last
    for (int i = n - 1; i >= 0; i--) begin
      b = eras[i] ? 1'($urandom) : (cw[i] ^ errs[i]);
      drive_beat(1'b1, i == n - 1, i == 0, b, eras[i], tag);
    end
    // copy c differs on errors and on erasures where the bit is not c
    ptr_q.push_back(tag);
    mask0_q.push_back(errs | (eras & cw));
    mask1_q.push_back(errs | (eras & ~cw));
  endtask

  task automatic drive_all();
    for (int w = 0; w < n_words; w++) begin
      // mostly back to back, an occasional idle beat
      if ($urandom % 8 == 0) begin
        drive_beat(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
      end
      send_codeword(ptr_t'(w));
    end
    drive_beat(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
  endtask

  // --------------------------------------------------------------------------
  // checking
  // --------------------------------------------------------------------------

  task automatic check_result();
    data_t        lp [0:t];
    logic [n-1:0] mask [2];
    ptr_t         exp_ptr;
    if (ptr_q.size() == 0) begin
      abort_with("locator strobe with no codeword outstanding");
    end
    exp_ptr = ptr_q.pop_front();
    mask[0] = mask0_q.pop_front();
    mask[1] = mask1_q.pop_front();
    check_eq("oloc_poly_ptr", int'(oloc_poly_ptr), int'(exp_ptr));
    for (int c = 0; c < 2; c++) begin
      lp = oloc_poly[c];
      // clean copy gives a constant locator
      if (mask[c] == '0) begin
        for (int k = 1; k <= t; k++) begin
          check_eq($sformatf("oloc_poly[%0d][%0d]", c, k), int'(lp[k]), 0);
        end
      end
      // beyond t the copy is not decodable
      if ($countones(mask[c]) <= t) begin
        check_eq($sformatf("oloc_poly[%0d][0] nonzero", c), int'(lp[0] != '0), 1);
        for (int i = 0; i < n; i++) begin
          check_eq($sformatf("oloc_poly[%0d] root at x^%0d", c, i),
                   int'(eval_at_inverse(lp, i) == 0), int'(mask[c][i]));
        end
      end
    end
  endtask

  // sampled at the falling edge, one result per enabled strobe cycle
  task automatic collect_results();
    int   cyc;
    logic got;
    for (int w = 0; w < n_words; w++) begin
      cyc = 0;
      got = 1'b0;
      while (!got) begin
        @(negedge iclk);
        if (ireset) begin
          check_eq("oloc_poly_val", int'(oloc_poly_val), 0);
        end else if (oloc_poly_val && iclkena) begin
          got = 1'b1;
          check_result();
        end
        cyc++;
        if (!got && cyc >= timeout_cycles) begin
          abort_with("no locator polynomial within 200 cycles");
        end
      end
    end
  endtask

  initial begin
    iclkena = 1'b1;
    ireset  = 1'b1;
    ival    = 1'b0;
    isop    = 1'b0;
    ieop    = 1'b0;
    idat    = 1'b0;
    iera    = 1'b0;
    iptr    = '0;
    void'($urandom(32'hc93));
    build_tables();
    fork
      begin
        repeat (5) @(posedge iclk);
        #1;
        ireset = 1'b0;
        drive_all();
      end
      collect_results();
    join
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== hdl/bch_eras_decoder.sv ====
module bch_eras_decoder
  import bch_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  input  logic  iclkena,
  input  logic  ival,
  input  logic  isop,
  input  logic  ieop,
  input  logic  idat,
  input  logic  iera,
  input  ptr_t  iptr,
  output logic  oloc_poly_val,
  output ptr_t  oloc_poly_ptr,
  output data_t oloc_poly [2][0:t]
);

  // --------------------------------------------------------------------------
  // calculator to buffer
  // --------------------------------------------------------------------------

  logic  syn_val;
  ptr_t  syn_ptr;
  data_t syn [2][1:t2];

  // buffer to solver
  logic  buf_val;
  ptr_t  buf_ptr;
  data_t buf_syn [2][1:t2];
  logic  sol_ready;

  bch_syndrome_calc u_syn (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .isop    (isop),
    .ieop    (ieop),
    .idat    (idat),
    .iera    (iera),
    .iptr    (iptr),
    .syn_val (syn_val),
    .syn_ptr (syn_ptr),
    .syn     (syn)
  );

  // lets the next frame finish while the solver is busy
  bch_syndrome_buffer u_buf (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .syn_val   (syn_val),
    .sol_ready (sol_ready),
    .syn_ptr   (syn_ptr),
    .syn       (syn),
    .buf_val   (buf_val),
    .buf_ptr   (buf_ptr),
    .buf_syn   (buf_syn)
  );

  bch_eras_berlekamp_ribm_2t u_sol (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .isyndrome_val (buf_val),
    .isyndrome_ptr (buf_ptr),
    .isyndrome     (buf_syn),
    .oready        (sol_ready),
    .oloc_poly_val (oloc_poly_val),
    .oloc_poly_ptr (oloc_poly_ptr),
    .oloc_poly     (oloc_poly)
  );

endmodule

// ==== hdl/bch_eras_berlekamp_ribm_2t.sv ====
module bch_eras_berlekamp_ribm_2t
  import bch_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  input  logic  iclkena,
  input  logic  isyndrome_val,
  input  ptr_t  isyndrome_ptr,
  input  data_t isyndrome [2][1:t2],
  output logic  oready,
  output logic  oloc_poly_val,
  output ptr_t  oloc_poly_ptr,
  output data_t oloc_poly [2][0:t]
);

  // chain length of the reformulated algorithm, indices 0..3t
  localparam int last = 3 * t;

  // --------------------------------------------------------------------------
  // state
  // --------------------------------------------------------------------------

  typedef enum logic [2:0] {
    st_reset,
    st_wait,
    st_step1,
    st_step2,
    st_reload,
    st_step11,
    st_step12
  } state_t;

  state_t state;

  // discrepancy chain and its shadow
  data_t gamma [0:last];
  data_t theta [0:last];
  data_t gamma_next [0:last];
  data_t theta_next [0:last];

  // gamma scale and the length balance
  data_t                 sigma;
  logic signed [kv_w-1:0] kv;
  logic                  upd;

  // copy 1 syndromes kept for the second half-pass
  data_t syn1_latched [1:t2];
  ptr_t  ptr_latched;

  logic [cnt_w-1:0] cnt;
  logic             cnt_done;
  logic             is_step;
  data_t            loc0 [0:t];

  assign cnt_done = (cnt == cnt_w'(1));
  assign is_step  = (state == st_step1) || (state == st_step2) ||
                    (state == st_step11) || (state == st_step12);
  assign oready   = (state == st_wait);

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state         <= st_reset;
      oloc_poly_val <= 1'b0;
    end else if (iclkena) begin
      // done strobe lines up with the last copy 1 update
      oloc_poly_val <= (state == st_step12) && cnt_done;
      case (state)
        st_reset:  state <= st_wait;
        st_wait:   state <= isyndrome_val ? st_step1 : st_wait;
        st_step1:  state <= st_step2;
        st_step2:  state <= cnt_done ? st_reload : st_step1;
        st_reload: state <= st_step11;
        st_step11: state <= st_step12;
        st_step12: state <= cnt_done ? st_wait : st_step11;
        default:   state <= st_reset;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // one RiBM iteration
  // --------------------------------------------------------------------------

  always_comb begin
    // take the new shadow if discrepancy is live and kv non-negative
    upd = (gamma[0] != '0) && (kv >= 0);
    for (int i = 0; i < last; i++) begin
      gamma_next[i] = gf_mult(sigma, gamma[i+1]) ^ gf_mult(gamma[0], theta[i]);
      theta_next[i] = upd ? gamma[i+1] : theta[i];
    end
    // top of chain shifts in zero
    gamma_next[last] = gf_mult(gamma[0], theta[last]);
    theta_next[last] = upd ? '0 : theta[last];
  end

  // --------------------------------------------------------------------------
  // datapath, no reset
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // step pair counter
      if (state == st_wait || state == st_reload) begin
        cnt <= cnt_w'(t);
      end else if (state == st_step2 || state == st_step12) begin
        cnt <= cnt - cnt_w'(1);
      end

      // load copy 0 and latch copy 1 at acceptance
      if (state == st_wait && isyndrome_val) begin
        ptr_latched  <= isyndrome_ptr;
        syn1_latched <= isyndrome[1];
        for (int i = 0; i <= last; i++) begin
          if (i < t2) begin
            gamma[i] <= isyndrome[0][i+1];
            theta[i] <= isyndrome[0][i+1];
          end else begin
            gamma[i] <= (i == last) ? data_t'(1) : '0;
            theta[i] <= (i == last) ? data_t'(1) : '0;
          end
        end
        sigma <= data_t'(1);
        kv    <= '0;
      end

      // copy 0 locator sits at t..2t, keep it and start copy 1
      if (state == st_reload) begin
        for (int i = 0; i <= t; i++) begin
          loc0[i] <= gamma[t+i];
        end
        for (int i = 0; i <= last; i++) begin
          if (i < t2) begin
            gamma[i] <= syn1_latched[i+1];
            theta[i] <= syn1_latched[i+1];
          end else begin
            gamma[i] <= (i == last) ? data_t'(1) : '0;
            theta[i] <= (i == last) ? data_t'(1) : '0;
          end
        end
        sigma <= data_t'(1);
        kv    <= '0;
      end

      if (is_step) begin
        gamma <= gamma_next;
        theta <= theta_next;
        if (upd) begin
          sigma <= gamma[0];
          kv    <= -kv - 1;
        end else begin
          kv    <= kv + 1;
        end
      end
    end
  end

  // copy 1 read straight from the chain while the strobe is high
  assign oloc_poly_ptr = ptr_latched;
  assign oloc_poly[0]  = loc0;
  assign oloc_poly[1]  = gamma[t:t2];

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // the buffer may only present syndromes while the solver waits
  a_val_when_ready : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && isyndrome_val) |-> oready
  );

endmodule

// ==== hdl/bch_syndrome_buffer.sv ====
module bch_syndrome_buffer
  import bch_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  input  logic  iclkena,
  input  logic  syn_val,
  input  logic  sol_ready,
  input  ptr_t  syn_ptr,
  input  data_t syn     [2][1:t2],
  output logic  buf_val,
  output ptr_t  buf_ptr,
  output data_t buf_syn [2][1:t2]
);

  // --------------------------------------------------------------------------
  // two-entry circular store
  // --------------------------------------------------------------------------

  data_t mem_syn [2][2][1:t2];
  ptr_t  mem_ptr [2];

  logic       wr_idx;
  logic       rd_idx;
  logic [1:0] count;
  logic       pop;
  logic       full;

  assign full = (count == 2'd2);

  // buf_val blocks a second pop while sol_ready still reads high
  assign pop = (count != 2'd0) && sol_ready && !buf_val;

  // storage and output registers, no reset
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (syn_val) begin
        mem_syn[wr_idx] <= syn;
        mem_ptr[wr_idx] <= syn_ptr;
      end
      if (pop) begin
        buf_syn <= mem_syn[rd_idx];
        buf_ptr <= mem_ptr[rd_idx];
      end
    end
  end

  // pointers, count and pop strobe
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_idx  <= 1'b0;
      rd_idx  <= 1'b0;
      count   <= 2'd0;
      buf_val <= 1'b0;
    end else if (iclkena) begin
      buf_val <= pop;
      if (syn_val) begin
        wr_idx <= ~wr_idx;
      end
      if (pop) begin
        rd_idx <= ~rd_idx;
      end
      // simultaneous write and pop keep the count
      case ({syn_val, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // source must respect the frame spacing, otherwise an entry is lost
  a_no_write_full : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && syn_val) |-> !full
  );

  // solver must still be waiting when the popped entry is presented
  a_pop_taken : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && buf_val) |-> sol_ready
  );

endmodule

// ==== hdl/bch_syndrome_calc.sv ====
module bch_syndrome_calc
  import bch_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  input  logic  iclkena,
  input  logic  ival,
  input  logic  isop,
  input  logic  ieop,
  input  logic  idat,
  input  logic  iera,
  input  ptr_t  iptr,
  output logic  syn_val,
  output ptr_t  syn_ptr,
  output data_t syn [2][1:t2]
);

  // --------------------------------------------------------------------------
  // horner accumulators, one set per erasure copy
  // --------------------------------------------------------------------------

  data_t acc      [2][1:t2];
  data_t acc_next [2][1:t2];
  logic  bit_copy [2];
  ptr_t  ptr_hold;
  logic  frame_open;

  // erased bit forced low in copy 0, high in copy 1
  assign bit_copy[0] = idat & ~iera;
  assign bit_copy[1] = idat | iera;

  // acc * alpha^j + bit, restarted from zero on isop
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      for (int j = 1; j <= t2; j++) begin
        if (isop) begin
          acc_next[c][j] = data_t'(bit_copy[c]);
        end else begin
          acc_next[c][j] = gf_mult(acc[c][j], gf_alpha_pow(j)) ^ data_t'(bit_copy[c]);
        end
      end
    end
  end

  // payload, no reset
  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      acc <= acc_next;
      // tag sampled at frame start
      if (isop) begin
        ptr_hold <= iptr;
      end
      // final sets captured on the last beat
      if (ieop) begin
        syn     <= acc_next;
        syn_ptr <= isop ? iptr : ptr_hold;
      end
    end
  end

  // control
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      syn_val    <= 1'b0;
      frame_open <= 1'b0;
    end else if (iclkena) begin
      syn_val <= ival & ieop;
      if (ival && ieop) begin
        frame_open <= 1'b0;
      end else if (ival && isop) begin
        frame_open <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // a new frame must not start before the open one has ended
  a_no_early_sop : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && ival && isop) |-> !frame_open
  );

endmodule

// ==== hdl/bch_pkg.sv ====
package bch_pkg;

  // --------------------------------------------------------------------------
  // code parameters, binary BCH (15,5) over GF(2^4)
  // --------------------------------------------------------------------------

  // field width
  localparam int m      = 4;
  // code length 2^m - 1
  localparam int n      = 15;
  // design distance
  localparam int d      = 7;
  // correction capability
  localparam int t      = (d - 1) / 2;
  // number of syndromes
  localparam int t2     = 2 * t;
  // x^4 + x + 1
  localparam int irrpol = 19;

  // solver step pair counter width
  localparam int cnt_w  = $clog2(t + 1);
  // solver kv register width, range -2t..2t
  localparam int kv_w   = $clog2(t2 + 1) + 1;

  // --------------------------------------------------------------------------
  // vector types
  // --------------------------------------------------------------------------

  // one field element
  typedef logic [m-1:0] data_t;
  // codeword tag
  typedef logic [3:0]   ptr_t;

  // --------------------------------------------------------------------------
  // GF(2^m) helpers
  // --------------------------------------------------------------------------

  // shift-and-add product, msb of b first
  function automatic data_t gf_mult(input data_t a, input data_t b);
    data_t r;
    logic  msb;
    r = '0;
    for (int i = m - 1; i >= 0; i--) begin
      msb = r[m-1];
      r = {r[m-2:0], 1'b0};
      // reduce by the field polynomial
      if (msb) begin
        r = r ^ data_t'(irrpol);
      end
      if (b[i]) begin
        r = r ^ a;
      end
    end
    return r;
  endfunction

  // alpha^p, exponent taken mod n
  function automatic data_t gf_alpha_pow(input int p);
    data_t r;
    int    e;
    r = data_t'(1);
    e = p % n;
    if (e < 0) begin
      e = e + n;
    end
    for (int i = 0; i < e; i++) begin
      // alpha is x, so multiply by 2
      r = gf_mult(r, data_t'(2));
    end
    return r;
  endfunction

endpackage
